/* rtl/trap_pkg.sv */
package trap_pkg;

	// data and address width
	localparam int XLEN = 32;

	// system instructions recognized at a boundary
	localparam logic [XLEN-1:0] INSTR_ECALL  = 32'h0000_0073;
	localparam logic [XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;
	localparam logic [XLEN-1:0] INSTR_MRET   = 32'h3020_0073;

	// machine CSR addresses
	localparam int CSR_ADDR_W = 12;

	localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
	localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
	localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
	localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

	// mcause values
	localparam logic [XLEN-1:0] CAUSE_ECALL  = 32'd11;
	localparam logic [XLEN-1:0] CAUSE_EBREAK = 32'd3;
	// interrupt flag in the top bit, machine timer is code 7
	localparam logic [XLEN-1:0] CAUSE_MTIMER = 32'h8000_0007;

	// mstatus bit positions
	localparam int MSTATUS_MIE  = 3;
	localparam int MSTATUS_MPIE = 7;

	// kind of request passed from decode to the sequencer
	typedef enum logic [1:0] {
		TRAP_NONE  = 2'd0,
		TRAP_SYNC  = 2'd1,
		TRAP_ASYNC = 2'd2,
		TRAP_MRET  = 2'd3
	} trap_kind_e;

endpackage

/* rtl/trap_decode.sv */
module trap_decode
	import trap_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            instr_valid_i,
	input  logic [XLEN-1:0] instr_i,
	input  logic [XLEN-1:0] pc_i,
	input  logic            jump_flag_i,
	input  logic [XLEN-1:0] jump_addr_i,
	input  logic            timer_pending_i,
	input  logic            mie_i,
	input  logic            busy_i,
	output trap_kind_e      req_kind_o,
	output logic [XLEN-1:0] req_epc_o,
	output logic [XLEN-1:0] req_cause_o
);

	trap_kind_e      kind_d;
	logic [XLEN-1:0] epc_d;
	logic [XLEN-1:0] cause_d;
	logic            accept;

	// boundaries arriving while a trap is in flight are dropped
	assign accept = instr_valid_i && !busy_i;

	// fixed priority: exceptions, then mret, then timer
	always_comb begin
		kind_d  = TRAP_NONE;
		epc_d   = pc_i;
		cause_d = '0;
		if (instr_i == INSTR_ECALL) begin
			kind_d  = TRAP_SYNC;
			cause_d = CAUSE_ECALL;
		end else if (instr_i == INSTR_EBREAK) begin
			kind_d  = TRAP_SYNC;
			cause_d = CAUSE_EBREAK;
		end else if (instr_i == INSTR_MRET) begin
			kind_d = TRAP_MRET;
		end else if (timer_pending_i && mie_i) begin
			kind_d  = TRAP_ASYNC;
			cause_d = CAUSE_MTIMER;
			// resume at the branch target if execute is redirecting
			epc_d   = jump_flag_i ? jump_addr_i : pc_i;
		end
	end

	// single-cycle request
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_kind_o <= TRAP_NONE;
		end else if (accept) begin
			req_kind_o <= kind_d;
		end else begin
			req_kind_o <= TRAP_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_epc_o   <= epc_d;
			req_cause_o <= cause_d;
		end
	end

endmodule

/* rtl/mtimer.sv */
module mtimer #(
	parameter int MTIME_W = 64
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               mtimecmp_we_i,
	input  logic [MTIME_W-1:0] mtimecmp_wdata_i,
	output logic               timer_pending_o
);

	logic [MTIME_W-1:0] mtime_q;
	logic [MTIME_W-1:0] mtimecmp_q;

	// free-running counter, wraps at full width
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtime_q <= '0;
		end else begin
			mtime_q <= mtime_q + 1'b1;
		end
	end

	// compare starts at all ones so nothing fires out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtimecmp_q <= '1;
		end else if (mtimecmp_we_i) begin
			mtimecmp_q <= mtimecmp_wdata_i;
		end
	end

	// level, drops in the cycle after a compare write moves it ahead
	assign timer_pending_o = (mtime_q >= mtimecmp_q);

endmodule

/* rtl/trap_ctrl.sv */
module trap_ctrl
	import trap_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  trap_kind_e            req_kind_i,
	input  logic [XLEN-1:0]       req_epc_i,
	input  logic [XLEN-1:0]       req_cause_i,
	input  logic [XLEN-1:0]       mstatus_i,
	input  logic [XLEN-1:0]       mtvec_i,
	input  logic [XLEN-1:0]       mepc_i,
	output logic                  busy_o,
	output logic                  trap_we_o,
	output logic [CSR_ADDR_W-1:0] trap_addr_o,
	output logic [XLEN-1:0]       trap_wdata_o,
	output logic                  int_assert_o,
	output logic [XLEN-1:0]       int_addr_o,
	output logic                  hold_o
);

	// one-hot sequencer states
	localparam logic [4:0] S_IDLE         = 5'b00001;
	localparam logic [4:0] S_WR_MEPC      = 5'b00010;
	localparam logic [4:0] S_WR_MSTATUS   = 5'b00100;
	localparam logic [4:0] S_WR_MCAUSE    = 5'b01000;
	localparam logic [4:0] S_MRET_MSTATUS = 5'b10000;

	logic [4:0]      state_q;
	logic [4:0]      state_d;
	logic [XLEN-1:0] epc_q;
	logic [XLEN-1:0] cause_q;
	logic            entry;

	assign entry = (state_q == S_IDLE) &&
		((req_kind_i == TRAP_SYNC) || (req_kind_i == TRAP_ASYNC));

	always_comb begin
		state_d = S_IDLE;
		case (state_q)
			S_IDLE: begin
				if (entry) begin
					state_d = S_WR_MEPC;
				end else if (req_kind_i == TRAP_MRET) begin
					state_d = S_MRET_MSTATUS;
				end
			end
			S_WR_MEPC:      state_d = S_WR_MSTATUS;
			S_WR_MSTATUS:   state_d = S_WR_MCAUSE;
			S_WR_MCAUSE:    state_d = S_IDLE;
			S_MRET_MSTATUS: state_d = S_IDLE;
			default:        state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// capture the request, it is only valid for one cycle
	always_ff @(posedge clk) begin
		if (entry) begin
			epc_q   <= req_epc_i;
			cause_q <= req_cause_i;
		end
	end

	// one CSR write per state
	always_comb begin
		trap_we_o    = 1'b0;
		trap_addr_o  = '0;
		trap_wdata_o = '0;
		case (state_q)
			S_WR_MEPC: begin
				trap_we_o    = 1'b1;
				trap_addr_o  = CSR_MEPC;
				trap_wdata_o = epc_q;
			end
			S_WR_MSTATUS: begin
				// stash MIE in MPIE and mask interrupts
				trap_we_o                  = 1'b1;
				trap_addr_o                = CSR_MSTATUS;
				trap_wdata_o               = mstatus_i;
				trap_wdata_o[MSTATUS_MPIE] = mstatus_i[MSTATUS_MIE];
				trap_wdata_o[MSTATUS_MIE]  = 1'b0;
			end
			S_WR_MCAUSE: begin
				trap_we_o    = 1'b1;
				trap_addr_o  = CSR_MCAUSE;
				trap_wdata_o = cause_q;
			end
			S_MRET_MSTATUS: begin
				// restore MIE, MPIE goes back to one
				trap_we_o                  = 1'b1;
				trap_addr_o                = CSR_MSTATUS;
				trap_wdata_o               = mstatus_i;
				trap_wdata_o[MSTATUS_MIE]  = mstatus_i[MSTATUS_MPIE];
				trap_wdata_o[MSTATUS_MPIE] = 1'b1;
			end
			default: begin
				trap_we_o = 1'b0;
			end
		endcase
	end

	// redirect pulse leaves with the last CSR write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			int_assert_o <= 1'b0;
		end else begin
			int_assert_o <= (state_q == S_WR_MCAUSE) || (state_q == S_MRET_MSTATUS);
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == S_WR_MCAUSE) begin
			int_addr_o <= mtvec_i;
		end else if (state_q == S_MRET_MSTATUS) begin
			int_addr_o <= mepc_i;
		end
	end

	// stall from the registered request through the pulse cycle
	assign busy_o = (req_kind_i != TRAP_NONE) || (state_q != S_IDLE) || int_assert_o;
	assign hold_o = busy_o;

endmodule

/* rtl/csr_file.sv */
module csr_file
	import trap_pkg::*;
#(
	parameter logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  trap_we_i,
	input  logic [CSR_ADDR_W-1:0] trap_addr_i,
	input  logic [XLEN-1:0]       trap_wdata_i,
	input  logic                  csr_we_i,
	input  logic [CSR_ADDR_W-1:0] csr_waddr_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	input  logic [CSR_ADDR_W-1:0] csr_raddr_i,
	output logic [XLEN-1:0]       csr_rdata_o,
	output logic [XLEN-1:0]       mstatus_o,
	output logic [XLEN-1:0]       mtvec_o,
	output logic [XLEN-1:0]       mepc_o,
	output logic                  mie_o
);

	logic                  mie_q;
	logic                  mpie_q;
	logic [XLEN-1:2]       mtvec_base_q;
	logic [XLEN-1:0]       mepc_q;
	logic [XLEN-1:0]       mcause_q;

	logic                  wr_en;
	logic [CSR_ADDR_W-1:0] wr_addr;
	logic [XLEN-1:0]       wr_data;
	logic [XLEN-1:0]       mstatus_val;

	// trap sequencer owns the port when it writes, software loses that cycle
	assign wr_en   = trap_we_i || csr_we_i;
	assign wr_addr = trap_we_i ? trap_addr_i : csr_waddr_i;
	assign wr_data = trap_we_i ? trap_wdata_i : csr_wdata_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mie_q        <= 1'b0;
			mpie_q       <= 1'b0;
			mtvec_base_q <= MTVEC_RESET[XLEN-1:2];
			mepc_q       <= '0;
			mcause_q     <= '0;
		end else if (wr_en) begin
			case (wr_addr)
				CSR_MSTATUS: begin
					mie_q  <= wr_data[MSTATUS_MIE];
					mpie_q <= wr_data[MSTATUS_MPIE];
				end
				// direct mode only, mode bits are not stored
				CSR_MTVEC:  mtvec_base_q <= wr_data[XLEN-1:2];
				CSR_MEPC:   mepc_q       <= wr_data;
				CSR_MCAUSE: mcause_q     <= wr_data;
				default: begin
					mcause_q <= mcause_q;
				end
			endcase
		end
	end

	// only MIE and MPIE are implemented
	always_comb begin
		mstatus_val               = '0;
		mstatus_val[MSTATUS_MIE]  = mie_q;
		mstatus_val[MSTATUS_MPIE] = mpie_q;
	end

	always_comb begin
		case (csr_raddr_i)
			CSR_MSTATUS: csr_rdata_o = mstatus_val;
			CSR_MTVEC:   csr_rdata_o = {mtvec_base_q, 2'b00};
			CSR_MEPC:    csr_rdata_o = mepc_q;
			CSR_MCAUSE:  csr_rdata_o = mcause_q;
			default:     csr_rdata_o = '0;
		endcase
	end

	assign mstatus_o = mstatus_val;
	assign mtvec_o   = {mtvec_base_q, 2'b00};
	assign mepc_o    = mepc_q;
	assign mie_o     = mie_q;

endmodule

/* rtl/trap_top.sv */
module trap_top
	import trap_pkg::*;
#(
	parameter int              MTIME_W     = 64,
	parameter logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
	input  logic                  clk,
	input  logic                  rst_n,
	// instruction boundary from the core
	input  logic                  instr_valid_i,
	input  logic [XLEN-1:0]       instr_i,
	input  logic [XLEN-1:0]       pc_i,
	input  logic                  jump_flag_i,
	input  logic [XLEN-1:0]       jump_addr_i,
	// timer compare write
	input  logic                  mtimecmp_we_i,
	input  logic [MTIME_W-1:0]    mtimecmp_wdata_i,
	// software CSR access
	input  logic                  csr_we_i,
	input  logic [CSR_ADDR_W-1:0] csr_waddr_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	input  logic [CSR_ADDR_W-1:0] csr_raddr_i,
	output logic [XLEN-1:0]       csr_rdata_o,
	// to the core pipeline
	output logic                  hold_o,
	output logic                  int_assert_o,
	output logic [XLEN-1:0]       int_addr_o
);

	trap_kind_e            req_kind;
	logic [XLEN-1:0]       req_epc;
	logic [XLEN-1:0]       req_cause;
	logic                  busy;
	logic                  timer_pending;
	logic                  mie;
	logic [XLEN-1:0]       mstatus;
	logic [XLEN-1:0]       mtvec;
	logic [XLEN-1:0]       mepc;
	logic                  trap_we;
	logic [CSR_ADDR_W-1:0] trap_addr;
	logic [XLEN-1:0]       trap_wdata;

	trap_decode u_trap_decode (
		.clk             (clk),
		.rst_n           (rst_n),
		.instr_valid_i   (instr_valid_i),
		.instr_i         (instr_i),
		.pc_i            (pc_i),
		.jump_flag_i     (jump_flag_i),
		.jump_addr_i     (jump_addr_i),
		.timer_pending_i (timer_pending),
		.mie_i           (mie),
		.busy_i          (busy),
		.req_kind_o      (req_kind),
		.req_epc_o       (req_epc),
		.req_cause_o     (req_cause)
	);

	mtimer #(
		.MTIME_W (MTIME_W)
	) u_mtimer (
		.clk              (clk),
		.rst_n            (rst_n),
		.mtimecmp_we_i    (mtimecmp_we_i),
		.mtimecmp_wdata_i (mtimecmp_wdata_i),
		.timer_pending_o  (timer_pending)
	);

	trap_ctrl u_trap_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_kind_i   (req_kind),
		.req_epc_i    (req_epc),
		.req_cause_i  (req_cause),
		.mstatus_i    (mstatus),
		.mtvec_i      (mtvec),
		.mepc_i       (mepc),
		.busy_o       (busy),
		.trap_we_o    (trap_we),
		.trap_addr_o  (trap_addr),
		.trap_wdata_o (trap_wdata),
		.int_assert_o (int_assert_o),
		.int_addr_o   (int_addr_o),
		.hold_o       (hold_o)
	);

	csr_file #(
		.MTVEC_RESET (MTVEC_RESET)
	) u_csr_file (
		.clk          (clk),
		.rst_n        (rst_n),
		.trap_we_i    (trap_we),
		.trap_addr_i  (trap_addr),
		.trap_wdata_i (trap_wdata),
		.csr_we_i     (csr_we_i),
		.csr_waddr_i  (csr_waddr_i),
		.csr_wdata_i  (csr_wdata_i),
		.csr_raddr_i  (csr_raddr_i),
		.csr_rdata_o  (csr_rdata_o),
		.mstatus_o    (mstatus),
		.mtvec_o      (mtvec),
		.mepc_o       (mepc),
		.mie_o        (mie)
	);

endmodule

/* sim/tb_trap_top.sv */
module tb_trap_top
	import trap_pkg::*;
();

	localparam int              MTIME_W     = 64;
	localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0400;
	localparam logic [XLEN-1:0] INSTR_NOP   = 32'h0000_0013;
	// the sequence below takes roughly 120 cycles
	localparam int TEST_CYCLES = 120;
	localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

	logic                  clk;
	logic                  rst_n;
	logic                  instr_valid_i;
	logic [XLEN-1:0]       instr_i;
	logic [XLEN-1:0]       pc_i;
	logic                  jump_flag_i;
	logic [XLEN-1:0]       jump_addr_i;
	logic                  mtimecmp_we_i;
	logic [MTIME_W-1:0]    mtimecmp_wdata_i;
	logic                  csr_we_i;
	logic [CSR_ADDR_W-1:0] csr_waddr_i;
	logic [XLEN-1:0]       csr_wdata_i;
	logic [CSR_ADDR_W-1:0] csr_raddr_i;
	logic [XLEN-1:0]       csr_rdata_o;
	logic                  hold_o;
	logic                  int_assert_o;
	logic [XLEN-1:0]       int_addr_o;

	integer          seed;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] jaddr;
	int              pulse_count;
	int              cycle_count;

	// reference model of timer, CSRs and the stall window
	logic [MTIME_W-1:0] mdl_mtime;
	logic [MTIME_W-1:0] mdl_cmp;
	logic               mdl_mie;
	logic               mdl_mpie;
	logic [XLEN-1:0]    mdl_mtvec;
	logic [XLEN-1:0]    mdl_mepc;
	logic [XLEN-1:0]    mdl_mcause;
	logic [2:0]         busy_cnt;
	logic               seq_mret;
	logic [XLEN-1:0]    seq_epc;
	logic [XLEN-1:0]    seq_cause;
	logic [XLEN-1:0]    exp_addr;

	trap_top #(
		.MTIME_W     (MTIME_W),
		.MTVEC_RESET (MTVEC_RESET)
	) u_trap_top (
		.clk              (clk),
		.rst_n            (rst_n),
		.instr_valid_i    (instr_valid_i),
		.instr_i          (instr_i),
		.pc_i             (pc_i),
		.jump_flag_i      (jump_flag_i),
		.jump_addr_i      (jump_addr_i),
		.mtimecmp_we_i    (mtimecmp_we_i),
		.mtimecmp_wdata_i (mtimecmp_wdata_i),
		.csr_we_i         (csr_we_i),
		.csr_waddr_i      (csr_waddr_i),
		.csr_wdata_i      (csr_wdata_i),
		.csr_raddr_i      (csr_raddr_i),
		.csr_rdata_o      (csr_rdata_o),
		.hold_o           (hold_o),
		.int_assert_o     (int_assert_o),
		.int_addr_o       (int_addr_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped after the first failure");
	endtask

	function automatic logic [XLEN-1:0] mstatus_word(input logic mpie, input logic mie);
		logic [XLEN-1:0] w;
		w               = '0;
		w[MSTATUS_MPIE] = mpie;
		w[MSTATUS_MIE]  = mie;
		return w;
	endfunction

	// trap entry holds for 5 cycles, mret for 3, pulse in the last one
	always @(posedge clk) begin : model_update
		logic trap_wr;
		logic pending;
		trap_wr = seq_mret ? (busy_cnt == 3'd2) : ((busy_cnt >= 3'd2) && (busy_cnt <= 3'd4));
		pending = (mdl_mtime >= mdl_cmp);
		if (!rst_n) begin
			mdl_mtime  <= '0;
			mdl_cmp    <= '1;
			mdl_mie    <= 1'b0;
			mdl_mpie   <= 1'b0;
			mdl_mtvec  <= {MTVEC_RESET[XLEN-1:2], 2'b00};
			mdl_mepc   <= '0;
			mdl_mcause <= '0;
			busy_cnt   <= 3'd0;
			seq_mret   <= 1'b0;
		end else begin
			mdl_mtime <= mdl_mtime + 64'd1;
			if (mtimecmp_we_i) begin
				mdl_cmp <= mtimecmp_wdata_i;
			end
			if (busy_cnt != 3'd0) begin
				busy_cnt <= busy_cnt - 3'd1;
			end
			if (busy_cnt == 3'd2) begin
				exp_addr <= seq_mret ? mdl_mepc : mdl_mtvec;
			end
			if (seq_mret && busy_cnt == 3'd2) begin
				mdl_mie  <= mdl_mpie;
				mdl_mpie <= 1'b1;
			end else if (!seq_mret && busy_cnt == 3'd4) begin
				mdl_mepc <= seq_epc;
			end else if (!seq_mret && busy_cnt == 3'd3) begin
				mdl_mpie <= mdl_mie;
				mdl_mie  <= 1'b0;
			end else if (!seq_mret && busy_cnt == 3'd2) begin
				mdl_mcause <= seq_cause;
			end
			// software write lost when the trap sequence owns the cycle
			if (csr_we_i && !trap_wr) begin
				case (csr_waddr_i)
					CSR_MSTATUS: begin
						mdl_mie  <= csr_wdata_i[MSTATUS_MIE];
						mdl_mpie <= csr_wdata_i[MSTATUS_MPIE];
					end
					CSR_MTVEC:  mdl_mtvec  <= {csr_wdata_i[XLEN-1:2], 2'b00};
					CSR_MEPC:   mdl_mepc   <= csr_wdata_i;
					CSR_MCAUSE: mdl_mcause <= csr_wdata_i;
					default:    mdl_mcause <= mdl_mcause;
				endcase
			end
			if (instr_valid_i && busy_cnt == 3'd0) begin
				seq_epc <= pc_i;
				if (instr_i == INSTR_ECALL || instr_i == INSTR_EBREAK) begin
					busy_cnt  <= 3'd5;
					seq_mret  <= 1'b0;
					seq_cause <= (instr_i == INSTR_ECALL) ? CAUSE_ECALL : CAUSE_EBREAK;
				end else if (instr_i == INSTR_MRET) begin
					busy_cnt <= 3'd3;
					seq_mret <= 1'b1;
				end else if (pending && mdl_mie) begin
					busy_cnt  <= 3'd5;
					seq_mret  <= 1'b0;
					seq_cause <= CAUSE_MTIMER;
					seq_epc   <= jump_flag_i ? jump_addr_i : pc_i;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (rst_n && int_assert_o) begin
			pulse_count <= pulse_count + 1;
		end
		if (cycle_count >= MAX_CYCLES) begin
			stop_with_failure($sformatf("timeout: run did not finish within %0d cycles",
				MAX_CYCLES));
		end
	end

	a_hold_window: assert property (@(posedge clk) disable iff (!rst_n)
		hold_o == (busy_cnt != 3'd0))
		else stop_with_failure($sformatf("ERR @%0t: hold_o outside its expected window", $time));

	a_pulse_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		int_assert_o == (busy_cnt == 3'd1))
		else stop_with_failure($sformatf("ERR @%0t: int_assert_o in the wrong cycle", $time));

	a_pulse_target: assert property (@(posedge clk) disable iff (!rst_n)
		int_assert_o |-> (int_addr_o == exp_addr))
		else stop_with_failure($sformatf("ERR @%0t: int_addr_o is not the redirect target",
			$time));

	task automatic wait_idle();
		@(posedge clk);
		while (hold_o) begin
			@(posedge clk);
		end
	endtask

	task automatic present(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] addr,
		input logic jflag, input logic [XLEN-1:0] jtarget);
		@(posedge clk);
		instr_valid_i <= 1'b1;
		instr_i       <= instr;
		pc_i          <= addr;
		jump_flag_i   <= jflag;
		jump_addr_i   <= jtarget;
		@(posedge clk);
		instr_valid_i <= 1'b0;
		jump_flag_i   <= 1'b0;
		wait_idle();
	endtask

	task automatic write_csr(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
		@(posedge clk);
		csr_we_i    <= 1'b1;
		csr_waddr_i <= addr;
		csr_wdata_i <= data;
		@(posedge clk);
		csr_we_i <= 1'b0;
	endtask

	task automatic write_cmp(input logic [MTIME_W-1:0] value);
		@(posedge clk);
		mtimecmp_we_i    <= 1'b1;
		mtimecmp_wdata_i <= value;
		@(posedge clk);
		mtimecmp_we_i <= 1'b0;
	endtask

	task automatic read_expect(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] exp,
		input string what);
		@(posedge clk);
		csr_raddr_i <= addr;
		@(posedge clk);
		assert (csr_rdata_o == exp)
			else stop_with_failure($sformatf("ERR @%0t: %s read %h, expected %h",
				$time, what, csr_rdata_o, exp));
	endtask

	task automatic expect_pulses(input int n, input string what);
		assert (pulse_count == n)
			else stop_with_failure($sformatf("ERR @%0t: %s saw %0d pulses, expected %0d",
				$time, what, pulse_count, n));
	endtask

	initial begin
		seed             = 32'hb56c6932;
		cycle_count      = 0;
		pulse_count      = 0;
		rst_n            = 1'b0;
		instr_valid_i    = 1'b0;
		instr_i          = '0;
		pc_i             = '0;
		jump_flag_i      = 1'b0;
		jump_addr_i      = '0;
		mtimecmp_we_i    = 1'b0;
		mtimecmp_wdata_i = '0;
		csr_we_i         = 1'b0;
		csr_waddr_i      = '0;
		csr_wdata_i      = '0;
		csr_raddr_i      = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		@(posedge clk);
		assert (!int_assert_o && !hold_o)
			else stop_with_failure($sformatf("ERR @%0t: outputs active after reset", $time));
		read_expect(CSR_MTVEC, MTVEC_RESET, "mtvec after reset");
		read_expect(CSR_MSTATUS, '0, "mstatus after reset");

		// ecall with MIE set, then mret
		write_csr(CSR_MTVEC, 32'h0000_2000);
		write_csr(CSR_MSTATUS, mstatus_word(1'b0, 1'b1));
		pc = $random(seed) & 32'hffff_fffc;
		present(INSTR_ECALL, pc, 1'b0, '0);
		expect_pulses(1, "ecall");
		read_expect(CSR_MEPC, pc, "mepc after ecall");
		read_expect(CSR_MCAUSE, CAUSE_ECALL, "mcause after ecall");
		read_expect(CSR_MSTATUS, mstatus_word(1'b1, 1'b0), "mstatus after ecall");
		present(INSTR_MRET, pc + 32'd4, 1'b0, '0);
		expect_pulses(2, "mret");
		read_expect(CSR_MSTATUS, mstatus_word(1'b1, 1'b1), "mstatus after mret");

		// ebreak with MIE clear
		write_csr(CSR_MSTATUS, '0);
		pc = $random(seed) & 32'hffff_fffc;
		present(INSTR_EBREAK, pc, 1'b0, '0);
		expect_pulses(3, "ebreak");
		read_expect(CSR_MEPC, pc, "mepc after ebreak");
		read_expect(CSR_MCAUSE, CAUSE_EBREAK, "mcause after ebreak");
		read_expect(CSR_MSTATUS, '0, "mstatus after ebreak");
		present(INSTR_MRET, pc + 32'd4, 1'b0, '0);
		expect_pulses(4, "second mret");
		read_expect(CSR_MSTATUS, mstatus_word(1'b1, 1'b0), "mstatus after second mret");

		// timer matched but masked
		write_cmp(64'd16);
		present(INSTR_NOP, 32'h0000_1000, 1'b0, '0);
		present(INSTR_NOP, 32'h0000_1004, 1'b0, '0);
		write_cmp('1);
		write_csr(CSR_MSTATUS, mstatus_word(1'b0, 1'b1));
		present(INSTR_NOP, 32'h0000_1008, 1'b0, '0);
		expect_pulses(4, "masked timer");

		// timer interrupt, plain and with a pending jump
		write_cmp(64'd16);
		pc = $random(seed) & 32'hffff_fffc;
		present(INSTR_NOP, pc, 1'b0, '0);
		expect_pulses(5, "timer");
		read_expect(CSR_MCAUSE, CAUSE_MTIMER, "mcause after timer");
		read_expect(CSR_MEPC, pc, "mepc after timer");
		read_expect(CSR_MSTATUS, mstatus_word(1'b1, 1'b0), "mstatus after timer");
		write_cmp('1);
		write_csr(CSR_MSTATUS, mstatus_word(1'b0, 1'b1));
		write_cmp(64'd16);
		jaddr = $random(seed) & 32'hffff_fffc;
		present(INSTR_NOP, pc + 32'd8, 1'b1, jaddr);
		expect_pulses(6, "timer with jump");
		read_expect(CSR_MEPC, jaddr, "mepc after timer with jump");
		write_cmp('1);

		// second ecall and csr writes during the stall window
		pc = $random(seed) & 32'hffff_fffc;
		@(posedge clk);
		instr_valid_i <= 1'b1;
		instr_i       <= INSTR_ECALL;
		pc_i          <= pc;
		@(posedge clk);
		instr_valid_i <= 1'b0;
		csr_we_i      <= 1'b1;
		csr_waddr_i   <= CSR_MTVEC;
		csr_wdata_i   <= 32'h0000_3000;
		@(posedge clk);
		csr_we_i      <= 1'b0;
		instr_valid_i <= 1'b1;
		pc_i          <= pc + 32'd4;
		@(posedge clk);
		instr_valid_i <= 1'b0;
		csr_we_i      <= 1'b1;
		csr_waddr_i   <= CSR_MEPC;
		csr_wdata_i   <= 32'hdead_0000;
		@(posedge clk);
		csr_we_i <= 1'b0;
		wait_idle();
		expect_pulses(7, "ecall during hold");
		read_expect(CSR_MTVEC, 32'h0000_3000, "mtvec written in the window");
		read_expect(CSR_MEPC, pc, "mepc with dropped write");
		read_expect(CSR_MCAUSE, mdl_mcause, "mcause after ecall in the window");

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* verilog.f */
rtl/trap_pkg.sv
rtl/trap_decode.sv
rtl/mtimer.sv
rtl/trap_ctrl.sv
rtl/csr_file.sv
rtl/trap_top.sv
sim/tb_trap_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the trap unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_trap_top \
	-f verilog.f \
	-o Vtb_trap_top

./obj_dir/Vtb_trap_top 2>&1 | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
	echo "simulation passed"
else
	echo "simulation did not pass"
	exit 1
fi
